//--- include/frontend_config.svh
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Fetch frontend build parameters
//////////////////////////////////////////////////////////////////////

// First fetch address out of reset
`define FE_RESET_PC 32'h1c00_0000

// BHT index width for 64 counters indexed by pc[7:2]
`define FE_BHT_IDX_W 6

// BTB index width for 16 entries
// Tag is whatever is left of pc above the index
`define FE_BTB_IDX_W 4

// Instruction buffer depth in entries
`define FE_IBUF_DEPTH 8

`endif

//--- logic/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Branch decode
    //////////////////////////////////////////////////////////////////////

    // Value of inst[31:26] that marks a branch
    localparam logic [5:0] BRANCH_OPCODE_HI = 6'h16;

    //////////////////////////////////////////////////////////////////////
    // Buffered fetch entry
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        // Decoded from the returned word
        logic        is_branch;
        // Prediction made when the pc was sent out
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_entry_t;

    //////////////////////////////////////////////////////////////////////
    // Backend training record
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        // Resolved direction and target
        logic        taken;
        logic [31:0] target;
    } branch_update_t;

endpackage

`default_nettype wire

//--- logic/pc_reg.sv
`default_nettype none

`include "frontend_config.svh"

module pc_reg (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         stall,
    input  wire         branch_flush,
    input  wire  [31:0] branch_actual_addr,
    input  wire         pred_taken,
    input  wire  [31:0] pred_target,
    output logic [31:0] pc,
    output logic        fetch_en
);

    // Fetch enable that stays off out of reset and for one cycle after a redirect
    logic        en_q;
    logic [31:0] pc_next;

    // Sequential or predicted successor
    always_comb begin
        if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch address register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc   <= `FE_RESET_PC;
            en_q <= 1'b0;
        end else if (branch_flush) begin
            // Redirect wins over everything and the request slot of this cycle is lost
            pc   <= branch_actual_addr;
            en_q <= 1'b0;
        end else begin
            en_q <= 1'b1;
            // Only move on once the current pc has been accepted
            if (en_q && !stall) begin
                pc <= pc_next;
            end
        end
    end

    assign fetch_en = en_q;

endmodule

`default_nettype wire

//--- logic/bpu.sv
`default_nettype none

`include "frontend_config.svh"

module bpu (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [31:0]                  pc,
    input  wire                          req_accept,
    input  wire  frontend_pkg::branch_update_t upd,
    input  wire  [31:0]                  icache_inst,
    input  wire                          icache_valid,
    output logic                         pred_taken,
    output logic [31:0]                  pred_target,
    output frontend_pkg::fetch_entry_t   resp_entry,
    output logic                         resp_valid
);

    import frontend_pkg::*;

    localparam int BHT_N = 1 << `FE_BHT_IDX_W;
    localparam int BTB_N = 1 << `FE_BTB_IDX_W;
    localparam int TAG_W = 30 - `FE_BTB_IDX_W;

    // Prediction tables
    logic [1:0]       bht [BHT_N];
    logic [BTB_N-1:0] btb_valid;
    logic [TAG_W-1:0] btb_tag [BTB_N];
    logic [31:0]      btb_target [BTB_N];

    logic [`FE_BHT_IDX_W-1:0] bht_idx;
    logic [`FE_BTB_IDX_W-1:0] btb_idx;
    logic                     btb_hit;

    logic [`FE_BHT_IDX_W-1:0] upd_bht_idx;
    logic [`FE_BTB_IDX_W-1:0] upd_btb_idx;
    logic                     btb_wr;

    // Request stage
    logic        pend_q;
    logic [31:0] pc_q;
    logic        pred_taken_q;
    logic [31:0] pred_target_q;

    //////////////////////////////////////////////////////////////////////
    // Lookup on the current fetch pc
    //////////////////////////////////////////////////////////////////////

    assign bht_idx = pc[`FE_BHT_IDX_W+1:2];
    assign btb_idx = pc[`FE_BTB_IDX_W+1:2];

    assign btb_hit = btb_valid[btb_idx] &&
                     (btb_tag[btb_idx] == pc[31:`FE_BTB_IDX_W+2]);

    // Taken needs a BTB hit and a counter of 2 or 3
    assign pred_taken  = btb_hit && bht[bht_idx][1];
    assign pred_target = btb_target[btb_idx];

    //////////////////////////////////////////////////////////////////////
    // Training from the backend
    //////////////////////////////////////////////////////////////////////

    assign upd_bht_idx = upd.pc[`FE_BHT_IDX_W+1:2];
    assign upd_btb_idx = upd.pc[`FE_BTB_IDX_W+1:2];
    assign btb_wr      = upd.valid && upd.taken;

    // Saturating 2-bit counters that start weakly not-taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_N; i++) begin
                bht[i] <= 2'd1;
            end
        end else if (upd.valid) begin
            if (upd.taken && bht[upd_bht_idx] != 2'd3) begin
                bht[upd_bht_idx] <= bht[upd_bht_idx] + 2'd1;
            end else if (!upd.taken && bht[upd_bht_idx] != 2'd0) begin
                bht[upd_bht_idx] <= bht[upd_bht_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btb_valid <= '0;
        end else if (btb_wr) begin
            btb_valid[upd_btb_idx] <= 1'b1;
        end
    end

    // Taken branches only allocate
    always_ff @(posedge clk) begin
        if (btb_wr) begin
            btb_tag[upd_btb_idx]    <= upd.pc[31:`FE_BTB_IDX_W+2];
            btb_target[upd_btb_idx] <= upd.target;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pair the prediction with the cache response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= req_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            pc_q          <= pc;
            pred_taken_q  <= pred_taken;
            pred_target_q <= pred_target;
        end
    end

    always_comb begin
        resp_entry.pc          = pc_q;
        resp_entry.inst        = icache_inst;
        resp_entry.is_branch   = (icache_inst[31:26] == BRANCH_OPCODE_HI);
        resp_entry.pred_taken  = pred_taken_q;
        resp_entry.pred_target = pred_target_q;
    end

    // Only responses to our own requests count
    assign resp_valid = icache_valid && pend_q;

endmodule

`default_nettype wire

//--- logic/instbuffer.sv
`default_nettype none

`include "frontend_config.svh"

module instbuffer #(
    parameter type payload_t = frontend_pkg::fetch_entry_t,
    parameter int  DEPTH     = `FE_IBUF_DEPTH
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       flush,
    input  wire       wr_en,
    input  wire       payload_t wr_data,
    input  wire       rd_en,
    output logic      rd_valid,
    output payload_t  rd_data,
    output logic      almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_fire;
    logic rd_fire;

    // Flush discards both the stored entries and any write this cycle
    assign wr_fire = wr_en && !flush;
    assign rd_fire = rd_en && rd_valid && !flush;

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    // One slot kept back for the response that may still be in flight
    assign almost_full = (count >= CNT_W'(DEPTH - 1));

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
`default_nettype none

`include "frontend_config.svh"

module frontend_top (
    input  wire                            clk,
    input  wire                            rst_n,

    // Instruction cache
    input  wire                            icache_stall,
    input  wire  [31:0]                    icache_inst,
    input  wire                            icache_valid,
    output logic [31:0]                    fetch_pc,
    output logic                           fetch_en,

    // Backend
    input  wire                            send_inst_en,
    input  wire  frontend_pkg::branch_update_t upd,
    input  wire                            branch_flush,
    input  wire  [31:0]                    branch_actual_addr,
    output logic                           out_valid,
    output frontend_pkg::fetch_entry_t     out_entry
);

    import frontend_pkg::*;

    logic         pc_fetch_en;
    logic         pc_stall;
    logic         req_accept;
    logic         pred_taken;
    logic [31:0]  pred_target;
    fetch_entry_t resp_entry;
    logic         resp_valid;
    logic         ibuf_almost_full;
    logic         flush_q;

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////

    // Buffer throttle holds the pc just like a cache stall
    assign pc_stall   = icache_stall || ibuf_almost_full;
    assign fetch_en   = pc_fetch_en && !ibuf_almost_full;
    assign req_accept = fetch_en && !icache_stall;

    pc_reg u_pc_reg (
        .clk,
        .rst_n,
        .stall              (pc_stall),
        .branch_flush,
        .branch_actual_addr,
        .pred_taken,
        .pred_target,
        .pc                 (fetch_pc),
        .fetch_en           (pc_fetch_en)
    );

    bpu u_bpu (
        .clk,
        .rst_n,
        .pc           (fetch_pc),
        .req_accept,
        .upd,
        .icache_inst,
        .icache_valid,
        .pred_taken,
        .pred_target,
        .resp_entry,
        .resp_valid
    );

    // Response to a request sent in the flush cycle is stale
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= branch_flush;
        end
    end

    instbuffer #(
        .payload_t (fetch_entry_t),
        .DEPTH     (`FE_IBUF_DEPTH)
    ) u_instbuffer (
        .clk,
        .rst_n,
        .flush       (branch_flush),
        .wr_en       (resp_valid && !flush_q),
        .wr_data     (resp_entry),
        .rd_en       (send_inst_en),
        .rd_valid    (out_valid),
        .rd_data     (out_entry),
        .almost_full (ibuf_almost_full)
    );

endmodule

`default_nettype wire

//--- sim/tb_frontend.sv
`default_nettype none

`include "frontend_config.svh"

module tb_frontend;

    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;

    // Phase budgets in cycles
    localparam int PH_SEQ   = 40;
    localparam int PH_TRAIN = 60;
    localparam int PH_FLUSH = 300;
    localparam int PH_BP    = 400;
    localparam int PH_MIX   = 2000;
    localparam int LIMIT    = 4 * (PH_SEQ + PH_TRAIN + PH_FLUSH + PH_BP + PH_MIX) + 200;

    // Directed training points
    localparam logic [31:0] P0    = `FE_RESET_PC + 32'h100;
    localparam logic [31:0] B_PC  = P0 + 32'h8;
    localparam logic [31:0] T_PC  = `FE_RESET_PC + 32'h240;

    logic           clk;
    logic           rst_n;
    logic           icache_stall;
    logic [31:0]    icache_inst;
    logic           icache_valid;
    logic           send_inst_en;
    branch_update_t upd;
    logic           branch_flush;
    logic [31:0]    branch_actual_addr;
    logic [31:0]    fetch_pc;
    logic           fetch_en;
    logic           out_valid;
    fetch_entry_t   out_entry;

    // Reference predictor
    logic [1:0]  bht_m [1 << `FE_BHT_IDX_W];
    logic        btb_v_m [1 << `FE_BTB_IDX_W];
    logic [31:0] btb_pc_m [1 << `FE_BTB_IDX_W];
    logic [31:0] btb_tgt_m [1 << `FE_BTB_IDX_W];

    logic [31:0]    exp_req_pc;
    logic [31:0]    exp_pc;
    logic [31:0]    acc_pc;
    logic           acc_q;
    logic           drain_level;
    branch_update_t trn;
    integer         seed;
    int             cycles;
    int             delivered;
    int             taken_seen;
    int             drain_left;

    frontend_top u_frontend_top (.*);

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] region_addr();
        return `FE_RESET_PC + 32'(rand_below(256) * 4);
    endfunction

    // Cache contents as a hash of the whole pc
    function automatic logic [31:0] mix_word(input logic [31:0] pc);
        logic [31:0] h;
        h = (pc ^ (pc >> 11)) * 32'h9e37_79b1;
        h = h ^ (h >> 16);
        // About one word in four becomes a branch
        if (h[5:4] == 2'b00) begin
            h[31:26] = BRANCH_OPCODE_HI;
        end
        return h;
    endfunction

    function automatic logic model_taken(input logic [31:0] pc);
        logic [`FE_BTB_IDX_W-1:0] bi;
        logic                     hit;
        bi  = pc[`FE_BTB_IDX_W+1:2];
        hit = btb_v_m[bi] && (btb_pc_m[bi][31:`FE_BTB_IDX_W+2] == pc[31:`FE_BTB_IDX_W+2]);
        return hit && (bht_m[pc[`FE_BHT_IDX_W+1:2]] >= 2'd2);
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] pc);
        return model_taken(pc) ? btb_tgt_m[pc[`FE_BTB_IDX_W+1:2]] : pc + 32'd4;
    endfunction

    task automatic model_train(input branch_update_t u);
        logic [`FE_BHT_IDX_W-1:0] hi;
        logic [`FE_BTB_IDX_W-1:0] bi;
        hi = u.pc[`FE_BHT_IDX_W+1:2];
        bi = u.pc[`FE_BTB_IDX_W+1:2];
        if (u.taken) begin
            if (bht_m[hi] != 2'd3) begin
                bht_m[hi] = bht_m[hi] + 2'd1;
            end
            btb_v_m[bi]   = 1'b1;
            btb_pc_m[bi]  = u.pc;
            btb_tgt_m[bi] = u.target;
        end else if (bht_m[hi] != 2'd0) begin
            bht_m[hi] = bht_m[hi] - 2'd1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
        $display("TB FAILED");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_fetch_pc(input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            report_mismatch("fetch_pc", exp_v, act_v);
        end
    endtask

    task automatic check_entry(input fetch_entry_t exp_e, input fetch_entry_t act_e);
        if (act_e.pc !== exp_e.pc) begin
            report_mismatch("out_entry.pc", exp_e.pc, act_e.pc);
        end
        if (act_e.inst !== exp_e.inst) begin
            report_mismatch("out_entry.inst", exp_e.inst, act_e.inst);
        end
        if (act_e.is_branch !== exp_e.is_branch) begin
            report_mismatch("out_entry.is_branch", {31'b0, exp_e.is_branch},
                            {31'b0, act_e.is_branch});
        end
        if (act_e.pred_taken !== exp_e.pred_taken) begin
            report_mismatch("out_entry.pred_taken", {31'b0, exp_e.pred_taken},
                            {31'b0, act_e.pred_taken});
        end
        // Target only means something on a taken prediction
        if (exp_e.pred_taken && act_e.pred_target !== exp_e.pred_target) begin
            report_mismatch("out_entry.pred_target", exp_e.pred_target, act_e.pred_target);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One clock cycle of stimulus, cache model and checking
    //////////////////////////////////////////////////////////////////////

    task automatic cycle(input logic stall, input logic drain, input logic flush,
                         input logic [31:0] addr, input branch_update_t u);
        fetch_entry_t exp_e;
        @(posedge clk);
        #1;
        // Response to the request accepted last cycle
        icache_valid       = acc_q;
        icache_inst        = acc_q ? mix_word(acc_pc) : 32'h0;
        icache_stall       = stall;
        send_inst_en       = drain;
        branch_flush       = flush;
        branch_actual_addr = addr;
        upd                = u;
        @(negedge clk);
        acc_q  = fetch_en && !icache_stall;
        acc_pc = fetch_pc;
        if (acc_q) begin
            check_fetch_pc(exp_req_pc, fetch_pc);
            exp_req_pc = model_next(exp_req_pc);
        end
        // Nothing leaves the buffer in a flush cycle
        if (out_valid && send_inst_en && !branch_flush) begin
            exp_e.pc          = exp_pc;
            exp_e.inst        = mix_word(exp_pc);
            exp_e.is_branch   = (exp_e.inst[31:26] == BRANCH_OPCODE_HI);
            exp_e.pred_taken  = model_taken(exp_pc);
            exp_e.pred_target = btb_tgt_m[exp_pc[`FE_BTB_IDX_W+1:2]];
            check_entry(exp_e, out_entry);
            taken_seen += out_entry.pred_taken;
            delivered++;
            exp_pc = model_next(exp_pc);
        end
        if (flush) begin
            exp_req_pc = addr;
            exp_pc     = addr;
        end
        if (u.valid) begin
            model_train(u);
        end
        cycles++;
        if (cycles > LIMIT) begin
            abort_run("Timeout: the run took more cycles than its limit");
        end
    endtask

    task automatic run_until(input int n);
        while (delivered < n) begin
            cycle(1'b0, 1'b1, 1'b0, 32'h0, '0);
        end
    endtask

    task automatic run_random(input int n, input int flush_den, input bit train, input bit bp);
        branch_update_t u;
        logic           flush;
        logic [31:0]    addr;
        for (int i = 0; i < n; i++) begin
            u     = '0;
            flush = (flush_den != 0) && (rand_below(flush_den) == 0);
            addr  = region_addr();
            // Training only rides along with a flush
            if (flush && train && rand_below(4) != 0) begin
                u.valid  = 1'b1;
                u.pc     = addr + 32'(rand_below(8) * 4);
                u.taken  = (rand_below(3) != 0);
                u.target = region_addr();
            end
            if (drain_left == 0) begin
                drain_level = !drain_level;
                drain_left  = 1 + rand_below(12);
            end
            drain_left--;
            cycle(rand_below(5) == 0, !bp || drain_level, flush, addr, u);
        end
    endtask

    initial begin
        seed               = 32'hc456;
        clk                = 1'b0;
        rst_n              = 1'b0;
        icache_stall       = 1'b0;
        icache_inst        = 32'h0;
        icache_valid       = 1'b0;
        send_inst_en       = 1'b0;
        upd                = '0;
        branch_flush       = 1'b0;
        branch_actual_addr = 32'h0;
        for (int i = 0; i < (1 << `FE_BHT_IDX_W); i++) begin
            bht_m[i] = 2'd1;
        end
        for (int i = 0; i < (1 << `FE_BTB_IDX_W); i++) begin
            btb_v_m[i] = 1'b0;
        end
        exp_req_pc  = `FE_RESET_PC;
        exp_pc      = `FE_RESET_PC;
        acc_q       = 1'b0;
        acc_pc      = 32'h0;
        drain_level = 1'b1;
        drain_left  = 0;
        cycles      = 0;
        delivered   = 0;
        taken_seen  = 0;

        // Two reset cycles and then the cycle after release
        @(posedge clk);
        @(negedge clk);
        if (fetch_en !== 1'b0 || out_valid !== 1'b0) begin
            abort_run("fetch_en or out_valid was not low during reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (fetch_en !== 1'b0 || out_valid !== 1'b0) begin
            abort_run("fetch_en or out_valid was not low in the cycle after reset");
        end

        // Straight-line fetch from the reset pc
        run_until(24);

        // Two taken updates for B_PC that each flush back to P0
        trn        = '0;
        trn.valid  = 1'b1;
        trn.pc     = B_PC;
        trn.taken  = 1'b1;
        trn.target = T_PC;
        repeat (2) cycle(1'b0, 1'b1, 1'b1, P0, trn);
        taken_seen = 0;
        run_until(delivered + 6);
        if (taken_seen == 0) begin
            abort_run("Trained branch was never predicted taken");
        end
        trn.taken = 1'b0;
        repeat (2) cycle(1'b0, 1'b1, 1'b1, P0, trn);
        taken_seen = 0;
        run_until(delivered + 6);
        if (taken_seen != 0) begin
            abort_run("Branch was still predicted taken after not-taken training");
        end

        run_random(PH_FLUSH, 12, 1'b0, 1'b0);
        run_random(PH_BP, 0, 1'b0, 1'b1);
        run_random(PH_MIX, 24, 1'b1, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
logic/frontend_pkg.sv
logic/pc_reg.sv
logic/bpu.sv
logic/instbuffer.sv
logic/frontend_top.sv
sim/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - include
    files:
      - logic/frontend_pkg.sv
      - logic/pc_reg.sv
      - logic/bpu.sv
      - logic/instbuffer.sv
      - logic/frontend_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_frontend.sv
